// ==== source/br_pkg.sv ====
`default_nettype none

package br_pkg;

    // datapath and register file sizes
    localparam int xlen     = 32;
    localparam int num_phys = 64;
    localparam int tag_w    = $clog2(num_phys); // physical tag width, 6

    // reservation station sizing
    localparam int rs_depth = 16;
    localparam int idx_w    = $clog2(rs_depth); // queue index width, 4

    // broadcast ports: 0 alu, 1 mul, 2 load, 3 branch link write
    localparam int num_wb   = 4;

    // branch condition codes, funct3 field of the B-type encoding
    localparam logic [2:0] f3_beq  = 3'b000;
    localparam logic [2:0] f3_bne  = 3'b001;
    localparam logic [2:0] f3_blt  = 3'b100;
    localparam logic [2:0] f3_bge  = 3'b101;
    localparam logic [2:0] f3_bltu = 3'b110;
    localparam logic [2:0] f3_bgeu = 3'b111;

    // 010 and 011 are not branches
    // the unit treats them as never taken

endpackage

`default_nettype wire

// ==== source/wakeup_if.sv ====
`default_nettype none

// result broadcast bus, one strobe per port per cycle
interface wakeup_if import br_pkg::*; ();

    logic [num_wb-1:0]            wb_valid;
    logic [num_wb-1:0][tag_w-1:0] wb_tag;   // destination physical tag
    logic [num_wb-1:0][xlen-1:0]  wb_data;

    modport bus (
        output wb_valid,
        output wb_tag,
        output wb_data
    );

    modport listen (
        input wb_valid,
        input wb_tag,
        input wb_data
    );

endinterface

`default_nettype wire

// ==== source/br_issue_if.sv ====
`default_nettype none

// one issued branch or jump, valid is a single cycle strobe
interface br_issue_if import br_pkg::*; ();

    logic             valid;
    logic [xlen-1:0]  inst_num;
    logic [xlen-1:0]  pc;
    logic [xlen-1:0]  imm;
    logic [2:0]       funct3;
    logic             is_branch;
    logic             is_jump;
    logic             is_jalr;     // also has is_jump set
    logic [tag_w-1:0] rd_tag;
    logic [tag_w-1:0] src1_tag;
    logic [tag_w-1:0] src2_tag;
    logic             pred_taken;
    logic [xlen-1:0]  pred_target;

    modport issue (
        output valid, inst_num, pc, imm, funct3, is_branch, is_jump, is_jalr,
        output rd_tag, src1_tag, src2_tag, pred_taken, pred_target
    );

    modport exec (
        input valid, inst_num, pc, imm, funct3, is_branch, is_jump, is_jalr,
        input rd_tag, src1_tag, src2_tag, pred_taken, pred_target
    );

endinterface

`default_nettype wire

// ==== source/br_rs.sv ====
`default_nettype none

module br_rs import br_pkg::*; (
    input  logic             clk,
    input  logic             reset,
    input  logic             dispatch_valid,
    input  logic [xlen-1:0]  dispatch_inst_num,
    input  logic [xlen-1:0]  dispatch_pc,
    input  logic [xlen-1:0]  dispatch_imm,
    input  logic [2:0]       dispatch_funct3,
    input  logic             dispatch_is_branch,
    input  logic             dispatch_is_jump,
    input  logic             dispatch_is_jalr,
    input  logic [tag_w-1:0] dispatch_rd_tag,
    input  logic [tag_w-1:0] dispatch_src1_tag,
    input  logic [tag_w-1:0] dispatch_src2_tag,
    input  logic [1:0]       dispatch_src_ready, // bit 0 src1, bit 1 src2
    input  logic             dispatch_pred_taken,
    input  logic [xlen-1:0]  dispatch_pred_target,
    input  logic             flush,
    wakeup_if.listen         wb,
    br_issue_if.issue        issue,
    output logic             rs_full
);

    // entry payload written at dispatch only
    logic [xlen-1:0]  inst_num_q    [rs_depth];
    logic [xlen-1:0]  pc_q          [rs_depth];
    logic [xlen-1:0]  imm_q         [rs_depth];
    logic [2:0]       funct3_q      [rs_depth];
    logic             is_branch_q   [rs_depth];
    logic             is_jump_q     [rs_depth];
    logic             is_jalr_q     [rs_depth];
    logic [tag_w-1:0] rd_q          [rs_depth];
    logic [tag_w-1:0] src1_q        [rs_depth];
    logic [tag_w-1:0] src2_q        [rs_depth];
    logic             pred_taken_q  [rs_depth];
    logic [xlen-1:0]  pred_target_q [rs_depth];

    logic [rs_depth-1:0] ready1;
    logic [rs_depth-1:0] ready2;
    logic [rs_depth-1:0] wake1;
    logic [rs_depth-1:0] wake2;
    logic [idx_w-1:0]    head;
    logic [idx_w-1:0]    tail;
    logic [idx_w:0]      count; // 0 to rs_depth
    logic                disp_hit1;
    logic                disp_hit2;
    logic                accept;
    logic                issue_go;

    assign rs_full  = (count == (idx_w + 1)'(rs_depth));
    assign accept   = dispatch_valid && !rs_full && !flush;
    // only the head leaves once both ready bits are registered
    assign issue_go = (count != '0) && ready1[head] && ready2[head] && !flush;

    // tag match against every live broadcast port
    always_comb begin
        wake1     = '0;
        wake2     = '0;
        disp_hit1 = 1'b0;
        disp_hit2 = 1'b0;
        for (int p = 0; p < num_wb; p++) begin
            if (wb.wb_valid[p]) begin
                if (wb.wb_tag[p] == dispatch_src1_tag) disp_hit1 = 1'b1; // same cycle bypass
                if (wb.wb_tag[p] == dispatch_src2_tag) disp_hit2 = 1'b1;
                for (int e = 0; e < rs_depth; e++) begin
                    if (wb.wb_tag[p] == src1_q[e]) wake1[e] = 1'b1;
                    if (wb.wb_tag[p] == src2_q[e]) wake2[e] = 1'b1;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            head        <= '0;
            tail        <= '0;
            count       <= '0;
            ready1      <= '0;
            ready2      <= '0;
            issue.valid <= 1'b0;
        end else if (flush) begin
            // everything still queued is younger than the mispredicted branch
            head        <= '0;
            tail        <= '0;
            count       <= '0;
            ready1      <= '0;
            ready2      <= '0;
            issue.valid <= 1'b0;
        end else begin
            ready1 <= ready1 | wake1;
            ready2 <= ready2 | wake2;
            if (accept) begin
                ready1[tail] <= dispatch_src_ready[0] | disp_hit1;
                ready2[tail] <= dispatch_src_ready[1] | disp_hit2;
                tail         <= tail + 1'b1; // wraps since depth is a power of two
            end
            if (issue_go) head <= head + 1'b1;
            count       <= count + {{idx_w{1'b0}}, accept} - {{idx_w{1'b0}}, issue_go};
            issue.valid <= issue_go;
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            inst_num_q[tail]    <= dispatch_inst_num;
            pc_q[tail]          <= dispatch_pc;
            imm_q[tail]         <= dispatch_imm;
            funct3_q[tail]      <= dispatch_funct3;
            is_branch_q[tail]   <= dispatch_is_branch;
            is_jump_q[tail]     <= dispatch_is_jump;
            is_jalr_q[tail]     <= dispatch_is_jalr;
            rd_q[tail]          <= dispatch_rd_tag;
            src1_q[tail]        <= dispatch_src1_tag;
            src2_q[tail]        <= dispatch_src2_tag;
            pred_taken_q[tail]  <= dispatch_pred_taken;
            pred_target_q[tail] <= dispatch_pred_target;
        end
    end

    // issue payload only meaningful while issue.valid
    always_ff @(posedge clk) begin
        if (issue_go) begin
            issue.inst_num    <= inst_num_q[head];
            issue.pc          <= pc_q[head];
            issue.imm         <= imm_q[head];
            issue.funct3      <= funct3_q[head];
            issue.is_branch   <= is_branch_q[head];
            issue.is_jump     <= is_jump_q[head];
            issue.is_jalr     <= is_jalr_q[head];
            issue.rd_tag      <= rd_q[head];
            issue.src1_tag    <= src1_q[head];
            issue.src2_tag    <= src2_q[head];
            issue.pred_taken  <= pred_taken_q[head];
            issue.pred_target <= pred_target_q[head];
        end
    end

    a_no_dispatch_when_full: assert property (@(posedge clk) disable iff (reset)
        dispatch_valid && !flush |-> !rs_full)
        else $error("dispatch while reservation station full");

    // pointers must show a held entry one cycle before any issue strobe
    a_issue_from_occupied: assert property (@(posedge clk) disable iff (reset)
        issue.valid |-> $past((tail != head) || rs_full))
        else $error("issue from empty reservation station");

endmodule

`default_nettype wire

// ==== source/prf.sv ====
`default_nettype none

module prf import br_pkg::*; (
    input  logic             clk,
    input  logic             reset,
    wakeup_if.listen         wb,
    input  logic [tag_w-1:0] rd_tag1,
    input  logic [tag_w-1:0] rd_tag2,
    output logic [xlen-1:0]  rd_data1,
    output logic [xlen-1:0]  rd_data2
);

    logic [xlen-1:0] regs [num_phys];
    logic            dup_write;

    always_ff @(posedge clk) begin
        for (int p = 0; p < num_wb; p++) begin
            if (wb.wb_valid[p]) regs[wb.wb_tag[p]] <= wb.wb_data[p];
        end
    end

    // write-first, a broadcast in flight this cycle wins over the array
    always_comb begin
        rd_data1 = regs[rd_tag1];
        rd_data2 = regs[rd_tag2];
        for (int p = 0; p < num_wb; p++) begin
            if (wb.wb_valid[p] && wb.wb_tag[p] == rd_tag1) rd_data1 = wb.wb_data[p];
            if (wb.wb_valid[p] && wb.wb_tag[p] == rd_tag2) rd_data2 = wb.wb_data[p];
        end
    end

    // renaming gives each tag a single producer
    always_comb begin
        dup_write = 1'b0;
        for (int p = 0; p < num_wb; p++) begin
            for (int q = p + 1; q < num_wb; q++) begin
                if (wb.wb_valid[p] && wb.wb_valid[q] && wb.wb_tag[p] == wb.wb_tag[q])
                    dup_write = 1'b1;
            end
        end
    end

    a_single_writer: assert property (@(posedge clk) disable iff (reset) !dup_write)
        else $error("two broadcast ports wrote the same physical tag");

endmodule

`default_nettype wire

// ==== source/br_unit.sv ====
`default_nettype none

module br_unit import br_pkg::*; (
    input  logic             clk,
    input  logic             reset,
    br_issue_if.exec         issue,
    input  logic [xlen-1:0]  src1_data,
    input  logic [xlen-1:0]  src2_data,
    output logic             resolve_valid,
    output logic             resolve_taken,
    output logic             mispredict,
    output logic [xlen-1:0]  resolve_inst_num,
    output logic [xlen-1:0]  resolve_target,
    output logic [xlen-1:0]  redirect_pc,
    output logic             br_wb_valid,
    output logic [tag_w-1:0] br_wb_tag,
    output logic [xlen-1:0]  br_wb_data
);

    logic            cond;
    logic            taken;
    logic            mis;
    logic            accept;
    logic [xlen-1:0] target;
    logic [xlen-1:0] link;
    logic [xlen-1:0] next_pc;

    always_comb begin
        case (issue.funct3)
            f3_beq:  cond = (src1_data == src2_data);
            f3_bne:  cond = (src1_data != src2_data);
            f3_blt:  cond = ($signed(src1_data) < $signed(src2_data));
            f3_bge:  cond = ($signed(src1_data) >= $signed(src2_data));
            f3_bltu: cond = (src1_data < src2_data);
            f3_bgeu: cond = (src1_data >= src2_data);
            default: cond = 1'b0;
        endcase
    end

    assign taken   = issue.is_jump || (issue.is_branch && cond);
    // jalr clears bit 0 of the sum
    assign target  = issue.is_jalr ? ((src1_data + issue.imm) & ~xlen'(1))
                                   : (issue.pc + issue.imm);
    assign link    = issue.pc + xlen'(4);
    assign next_pc = taken ? target : link;
    assign mis     = (taken != issue.pred_taken) ||
                     (taken && target != issue.pred_target);

    // an issue landing on our own mispredict cycle is on the wrong path
    assign accept  = issue.valid && !mispredict;

    always_ff @(posedge clk) begin
        if (reset) begin
            resolve_valid <= 1'b0;
            mispredict    <= 1'b0;
            br_wb_valid   <= 1'b0;
        end else begin
            resolve_valid <= accept;
            mispredict    <= accept && mis;
            br_wb_valid   <= accept && issue.is_jump; // link write for jal and jalr
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            resolve_taken    <= taken;
            resolve_inst_num <= issue.inst_num;
            resolve_target   <= target;
            redirect_pc      <= next_pc;
            br_wb_tag        <= issue.rd_tag;
            br_wb_data       <= link;
        end
    end

    // mispredict rides on a resolve and the station stops issuing right after
    a_mispredict_flush: assert property (@(posedge clk) disable iff (reset)
        mispredict |-> resolve_valid ##1 !issue.valid)
        else $error("mispredict without resolve or issue not flushed");

endmodule

`default_nettype wire

// ==== source/br_top.sv ====
`default_nettype none

module br_top import br_pkg::*; (
    input  logic             clk,
    input  logic             reset,
    input  logic             dispatch_valid,
    input  logic [xlen-1:0]  dispatch_inst_num,
    input  logic [xlen-1:0]  dispatch_pc,
    input  logic [xlen-1:0]  dispatch_imm,
    input  logic [2:0]       dispatch_funct3,
    input  logic             dispatch_is_branch,
    input  logic             dispatch_is_jump,
    input  logic             dispatch_is_jalr,
    input  logic [tag_w-1:0] dispatch_rd_tag,
    input  logic [tag_w-1:0] dispatch_src1_tag,
    input  logic [tag_w-1:0] dispatch_src2_tag,
    input  logic [1:0]       dispatch_src_ready,
    input  logic             dispatch_pred_taken,
    input  logic [xlen-1:0]  dispatch_pred_target,
    output logic             rs_full,
    input  logic             alu_wb_valid,
    input  logic [tag_w-1:0] alu_wb_tag,
    input  logic [xlen-1:0]  alu_wb_data,
    input  logic             mul_wb_valid,
    input  logic [tag_w-1:0] mul_wb_tag,
    input  logic [xlen-1:0]  mul_wb_data,
    input  logic             load_wb_valid,
    input  logic [tag_w-1:0] load_wb_tag,
    input  logic [xlen-1:0]  load_wb_data,
    output logic             resolve_valid,
    output logic             resolve_taken,
    output logic             mispredict,
    output logic [xlen-1:0]  resolve_inst_num,
    output logic [xlen-1:0]  resolve_target,
    output logic [xlen-1:0]  redirect_pc,
    output logic             br_wb_valid,
    output logic [tag_w-1:0] br_wb_tag,
    output logic [xlen-1:0]  br_wb_data
);

    logic [xlen-1:0] src1_data;
    logic [xlen-1:0] src2_data;

    wakeup_if   wb ();
    br_issue_if issue ();

    // port order 0 alu, 1 mul, 2 load, 3 branch link
    assign wb.wb_valid = {br_wb_valid, load_wb_valid, mul_wb_valid, alu_wb_valid};
    assign wb.wb_tag   = {br_wb_tag, load_wb_tag, mul_wb_tag, alu_wb_tag};
    assign wb.wb_data  = {br_wb_data, load_wb_data, mul_wb_data, alu_wb_data};

    br_rs u_rs (.*, .flush(mispredict));

    prf u_prf (
        .clk      (clk),
        .reset    (reset),
        .wb       (wb),
        .rd_tag1  (issue.src1_tag),
        .rd_tag2  (issue.src2_tag),
        .rd_data1 (src1_data),
        .rd_data2 (src2_data)
    );

    br_unit u_br (.*);

endmodule

`default_nettype wire

// ==== verif/br_tb.sv ====
`default_nettype none

module br_tb import br_pkg::*; ();

    localparam int k_branch = 0;
    localparam int k_jal    = 1;
    localparam int k_jalr   = 2;
    localparam int max_id   = 512;
    localparam int timeout  = 300; // cycles per wait

    logic clk;
    logic reset;
    logic dispatch_valid, dispatch_is_branch, dispatch_is_jump, dispatch_is_jalr;
    logic [xlen-1:0] dispatch_inst_num, dispatch_pc, dispatch_imm, dispatch_pred_target;
    logic [2:0] dispatch_funct3;
    logic [tag_w-1:0] dispatch_rd_tag, dispatch_src1_tag, dispatch_src2_tag;
    logic [1:0] dispatch_src_ready;
    logic dispatch_pred_taken, rs_full;
    logic alu_wb_valid, mul_wb_valid, load_wb_valid;
    logic [tag_w-1:0] alu_wb_tag, mul_wb_tag, load_wb_tag;
    logic [xlen-1:0] alu_wb_data, mul_wb_data, load_wb_data;
    logic resolve_valid, resolve_taken, mispredict, br_wb_valid;
    logic [xlen-1:0] resolve_inst_num, resolve_target, redirect_pc, br_wb_data;
    logic [tag_w-1:0] br_wb_tag;

    // reference model state
    logic [xlen-1:0] shadow [num_phys]; // register values as broadcast
    int              kind_r [max_id];
    logic [2:0]      f3_r   [max_id];
    logic [xlen-1:0] pc_r   [max_id];
    logic [xlen-1:0] imm_r  [max_id];
    logic [tag_w-1:0] s1_r [max_id];
    logic [tag_w-1:0] s2_r [max_id];
    logic [tag_w-1:0] rd_r [max_id];
    logic            pt_r   [max_id];
    logic [xlen-1:0] ptgt_r [max_id];
    int              order_q[$]; // ids in dispatch order
    int              next_id;
    logic [tag_w-1:0] tag_ctr;
    logic            pending_pop, fast_dispatch;
    logic            exp_have, exp_taken, exp_mis, exp_jump;
    logic [xlen-1:0] exp_num, exp_target, exp_next, exp_link;
    logic [tag_w-1:0] exp_rd;
    logic [2:0]      f3_list [6];

    br_top dut (.*);

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    task automatic fail_now(input string what);
        $display("%s", what);
        $display("Some tests failed");
        $fatal(1);
    endtask

    task automatic mismatch(input string name, input logic [xlen-1:0] exp, got);
        $display("FAIL time=%0t %s expected=%h actual=%h", $time, name, exp, got);
        $display("Some tests failed");
        $fatal(1);
    endtask

    function automatic logic cond_of(input logic [2:0] f3, input logic [xlen-1:0] a, b);
        case (f3)
            3'b000:  return a == b;
            3'b001:  return a != b;
            3'b100:  return $signed(a) < $signed(b);
            3'b101:  return !($signed(a) < $signed(b));
            3'b110:  return a < b;
            3'b111:  return !(a < b);
            default: return 1'b0;
        endcase
    endfunction

    function automatic logic [tag_w-1:0] alloc_tag();
        tag_ctr = (tag_ctr == tag_w'(num_phys - 1)) ? tag_w'(1) : tag_ctr + 1'b1;
        return tag_ctr;
    endfunction

    // strobes last one cycle
    task automatic next_cycle();
        @(negedge clk);
        dispatch_valid = 1'b0;
        fast_dispatch  = 1'b0;
        alu_wb_valid   = 1'b0;
        mul_wb_valid   = 1'b0;
        load_wb_valid  = 1'b0;
    endtask

    task automatic publish(input int port, input logic [tag_w-1:0] tag, input logic [xlen-1:0] v);
        shadow[tag] = v;
        case (port)
            0: begin
                alu_wb_valid = 1'b1;
                alu_wb_tag   = tag;
                alu_wb_data  = v;
            end
            1: begin
                mul_wb_valid = 1'b1;
                mul_wb_tag   = tag;
                mul_wb_data  = v;
            end
            default: begin
                load_wb_valid = 1'b1;
                load_wb_tag   = tag;
                load_wb_data  = v;
            end
        endcase
    endtask

    // a and b are the operand values the entry will see
    // correct picks a right or a wrong prediction
    task automatic send(input int kind, input logic [2:0] f3, input logic [tag_w-1:0] s1, s2,
                        input logic [1:0] rdy, input logic [tag_w-1:0] rd,
                        input logic [xlen-1:0] a, b, input bit correct, input bit fast);
        logic [xlen-1:0] pc;
        logic [xlen-1:0] imm;
        logic [xlen-1:0] tgt;
        logic            tk;
        pc  = $urandom & ~32'h3;
        imm = xlen'(signed'(12'($urandom))) & ~32'h1;
        tk  = (kind != k_branch) || cond_of(f3, a, b);
        tgt = (kind == k_jalr) ? ((a + imm) & ~32'h1) : pc + imm;
        if (!correct) begin
            if (kind != k_branch) tgt = tgt ^ 32'h10; // wrong target only
            else tk = !tk;
        end
        kind_r[next_id] = kind;
        f3_r[next_id]   = f3;
        pc_r[next_id]   = pc;
        imm_r[next_id]  = imm;
        s1_r[next_id]   = s1;
        s2_r[next_id]   = s2;
        rd_r[next_id]   = rd;
        pt_r[next_id]   = tk;
        ptgt_r[next_id] = tgt;
        if (kind != k_branch) shadow[rd] = pc + 4; // link value
        dispatch_valid       = 1'b1;
        dispatch_inst_num    = next_id;
        dispatch_pc          = pc;
        dispatch_imm         = imm;
        dispatch_funct3      = f3;
        dispatch_is_branch   = (kind == k_branch);
        dispatch_is_jump     = (kind != k_branch);
        dispatch_is_jalr     = (kind == k_jalr);
        dispatch_rd_tag      = rd;
        dispatch_src1_tag    = s1;
        dispatch_src2_tag    = s2;
        dispatch_src_ready   = rdy;
        dispatch_pred_taken  = tk;
        dispatch_pred_target = tgt;
        fast_dispatch = fast;
        order_q.push_back(next_id);
        next_id++;
    endtask

    task automatic wait_drain();
        int n;
        n = 0;
        while ((order_q.size() != 0 || resolve_valid) && n < timeout) begin
            next_cycle();
            n++;
        end
        if (n >= timeout) fail_now("timed out waiting for queued branches to resolve");
        next_cycle();
    endtask

    // expected values for the oldest entry settle well before the next rising edge
    always begin
        int id;
        logic [xlen-1:0] a;
        logic [xlen-1:0] b;
        @(negedge clk);
        #1;
        if (pending_pop && order_q.size() != 0) begin
            void'(order_q.pop_front());
            if (exp_mis) order_q.delete(); // younger entries are flushed
        end
        pending_pop = resolve_valid;
        exp_have = (order_q.size() != 0);
        if (exp_have) begin
            id = order_q[0];
            a = shadow[s1_r[id]];
            b = shadow[s2_r[id]];
            exp_num    = id;
            exp_jump   = (kind_r[id] != k_branch);
            exp_taken  = exp_jump || cond_of(f3_r[id], a, b);
            exp_target = (kind_r[id] == k_jalr) ? ((a + imm_r[id]) & ~32'h1)
                                                : pc_r[id] + imm_r[id];
            exp_link   = pc_r[id] + 4;
            exp_next   = exp_taken ? exp_target : exp_link;
            exp_mis    = (exp_taken != pt_r[id]) || (exp_taken && exp_target != ptgt_r[id]);
            exp_rd     = rd_r[id];
        end
    end

    a_expected: assert property (@(posedge clk) disable iff (reset) resolve_valid |-> exp_have)
        else fail_now("resolve_valid arrived with no branch outstanding");
    a_num: assert property (@(posedge clk) disable iff (reset)
        resolve_valid |-> resolve_inst_num == exp_num)
        else mismatch("resolve_inst_num", $sampled(exp_num), $sampled(resolve_inst_num));
    a_taken: assert property (@(posedge clk) disable iff (reset)
        resolve_valid |-> resolve_taken == exp_taken)
        else mismatch("resolve_taken", $sampled(exp_taken), $sampled(resolve_taken));
    a_target: assert property (@(posedge clk) disable iff (reset)
        resolve_valid |-> resolve_target == exp_target)
        else mismatch("resolve_target", $sampled(exp_target), $sampled(resolve_target));
    a_redirect: assert property (@(posedge clk) disable iff (reset)
        resolve_valid |-> redirect_pc == exp_next)
        else mismatch("redirect_pc", $sampled(exp_next), $sampled(redirect_pc));
    a_mis: assert property (@(posedge clk) disable iff (reset)
        resolve_valid |-> mispredict == exp_mis)
        else mismatch("mispredict", $sampled(exp_mis), $sampled(mispredict));
    a_link: assert property (@(posedge clk) disable iff (reset)
        resolve_valid |-> br_wb_valid == exp_jump)
        else mismatch("br_wb_valid", $sampled(exp_jump), $sampled(br_wb_valid));
    a_link_tag: assert property (@(posedge clk) disable iff (reset)
        br_wb_valid |-> br_wb_tag == exp_rd)
        else mismatch("br_wb_tag", $sampled(exp_rd), $sampled(br_wb_tag));
    a_link_data: assert property (@(posedge clk) disable iff (reset)
        br_wb_valid |-> br_wb_data == exp_link)
        else mismatch("br_wb_data", $sampled(exp_link), $sampled(br_wb_data));
    // dispatch edge, issue edge, resolve edge, then resolve_valid is sampled high
    a_fast: assert property (@(posedge clk) disable iff (reset)
        dispatch_valid && fast_dispatch |-> ##3 resolve_valid)
        else fail_now("ready branch into empty queue did not resolve two cycles later");

    initial begin
        logic [tag_w-1:0] ta, tb, tu, ty, rj;
        logic [xlen-1:0] va, vb, vu;
        void'($urandom(16041));
        f3_list = '{f3_beq, f3_bne, f3_blt, f3_bge, f3_bltu, f3_bgeu};
        next_id       = 0;
        tag_ctr       = '0;
        pending_pop   = 1'b0;
        exp_have      = 1'b0;
        exp_mis       = 1'b0;
        fast_dispatch = 1'b0;
        dispatch_valid       = 1'b0;
        dispatch_inst_num    = '0;
        dispatch_pc          = '0;
        dispatch_imm         = '0;
        dispatch_funct3      = '0;
        dispatch_is_branch   = 1'b0;
        dispatch_is_jump     = 1'b0;
        dispatch_is_jalr     = 1'b0;
        dispatch_rd_tag      = '0;
        dispatch_src1_tag    = '0;
        dispatch_src2_tag    = '0;
        dispatch_src_ready   = '0;
        dispatch_pred_taken  = 1'b0;
        dispatch_pred_target = '0;
        alu_wb_valid  = 1'b0;
        alu_wb_tag    = '0;
        alu_wb_data   = '0;
        mul_wb_valid  = 1'b0;
        mul_wb_tag    = '0;
        mul_wb_data   = '0;
        load_wb_valid = 1'b0;
        load_wb_tag   = '0;
        load_wb_data  = '0;
        reset = 1'b1;
        repeat (3) @(posedge clk);
        next_cycle();
        reset = 1'b0;

        // every condition code with ready operands
        for (int i = 0; i < 18; i++) begin
            next_cycle();
            ta = alloc_tag();
            tb = alloc_tag();
            va = $urandom;
            vb = ($urandom % 3 == 0) ? va : $urandom;
            publish(0, ta, va);
            publish(1, tb, vb);
            next_cycle();
            send(k_branch, f3_list[i % 6], ta, tb, 2'b11, '0, va, vb, $urandom % 2, 1);
            wait_drain();
        end

        // late operand then same cycle bypass
        tu = alloc_tag();
        vu = $urandom;
        send(k_branch, f3_bne, ta, tu, 2'b01, '0, va, vu, 1, 0);
        for (int i = 0; i < 4; i++) begin
            next_cycle();
            if (resolve_valid) fail_now("branch resolved before its late operand arrived");
        end
        publish(2, tu, vu);
        wait_drain();
        tu = alloc_tag();
        vu = $urandom;
        publish(2, tu, vu);
        send(k_branch, f3_bltu, ta, tu, 2'b01, '0, va, vu, 1, 1);
        wait_drain();

        // blocked head holds younger ready entries
        tu = alloc_tag();
        vu = $urandom;
        send(k_branch, f3_bge, tu, ta, 2'b10, '0, vu, va, 1, 0);
        next_cycle();
        send(k_branch, f3_beq, ta, ta, 2'b11, '0, va, va, 1, 0);
        next_cycle();
        send(k_branch, f3_blt, ta, tb, 2'b11, '0, va, vb, 1, 0);
        repeat (3) next_cycle();
        publish(0, tu, vu);
        wait_drain();

        // jal and jalr link writes wake dependents
        rj = alloc_tag();
        send(k_jal, 3'b000, ta, ta, 2'b11, rj, va, va, 1, 0);
        next_cycle();
        send(k_branch, f3_beq, rj, rj, 2'b00, '0, shadow[rj], shadow[rj], 1, 0);
        wait_drain();
        rj = alloc_tag();
        send(k_jalr, 3'b000, ta, ta, 2'b11, rj, va, va, 1, 0);
        next_cycle();
        send(k_branch, f3_bgeu, rj, ta, 2'b10, '0, shadow[rj], va, 1, 0);
        wait_drain();

        // outcome mispredict behind a blocker drops younger entries
        tu = alloc_tag();
        ty = alloc_tag();
        vu = $urandom;
        send(k_branch, f3_beq, tu, ta, 2'b10, '0, vu, va, 1, 0);
        next_cycle();
        send(k_branch, f3_list[$urandom % 6], ta, tb, 2'b11, '0, va, vb, 0, 0);
        next_cycle();
        send(k_branch, f3_bne, ty, ta, 2'b10, '0, '0, va, 1, 0);
        next_cycle();
        send(k_branch, f3_beq, ta, ta, 2'b11, '0, va, va, 1, 0);
        next_cycle();
        publish(1, tu, vu);
        wait_drain();
        repeat (5) next_cycle();
        assert (!rs_full) else fail_now("rs_full still high after a mispredict flush");

        // target mispredict on a jump
        rj = alloc_tag();
        send(k_jal, 3'b000, ta, ta, 2'b11, rj, va, va, 0, 0);
        next_cycle();
        send(k_branch, f3_beq, ta, ta, 2'b11, '0, va, va, 1, 0);
        wait_drain();
        repeat (5) next_cycle();
        assert (!rs_full) else fail_now("rs_full still high after a mispredict flush");

        // fill behind a blocked head and drain
        tu = alloc_tag();
        vu = $urandom;
        send(k_branch, f3_bltu, tu, tb, 2'b10, '0, vu, vb, 1, 0);
        for (int i = 1; i < rs_depth; i++) begin
            next_cycle();
            send(k_branch, f3_list[$urandom % 6], ta, tb, 2'b11, '0, va, vb, 1, 0);
        end
        next_cycle();
        assert (rs_full) else fail_now("rs_full low with every entry held");
        publish(2, tu, vu);
        wait_drain();

        if (order_q.size() == 0 && !rs_full) begin
            $display("All tests passed");
            $finish;
        end else begin
            fail_now("branches left outstanding at end of run");
        end
    end

endmodule

`default_nettype wire

// ==== sources.f ====
source/br_pkg.sv
source/wakeup_if.sv
source/br_issue_if.sv
source/br_rs.sv
source/prf.sv
source/br_unit.sv
source/br_top.sv
verif/br_tb.sv

// ==== Bender.yml ====
package:
  name: br_path

sources:
  - source/br_pkg.sv
  - source/wakeup_if.sv
  - source/br_issue_if.sv
  - source/br_rs.sv
  - source/prf.sv
  - source/br_unit.sv
  - source/br_top.sv
  - target: simulation
    files:
      - verif/br_tb.sv
